//--- dv/rv_core_chk.sv
`timescale 1ns/1ps

module rv_core_chk (
	input logic        clk,
	input logic        resetn,
	input logic        trap,
	input logic        mem_valid,
	input logic        mem_instr,
	input logic [31:0] mem_addr,
	input logic [31:0] mem_wdata,
	input logic [3:0]  mem_wstrb,
	input logic        mem_ready
);

	// Request held until the memory answers
	hold_until_ready: assert property (@(posedge clk) disable iff (!resetn)
		mem_valid && !mem_ready |=> mem_valid && $stable(mem_addr) && $stable(mem_wdata)
			&& $stable(mem_wstrb) && $stable(mem_instr))
		else $error("memory request changed before mem_ready");

	wstrb_legal: assert property (@(posedge clk) disable iff (!resetn)
		mem_valid |-> mem_wstrb == 4'b0000 || mem_wstrb == 4'b1111)
		else $error("partial write strobe on the memory port");

	trap_sticky: assert property (@(posedge clk) disable iff (!resetn)
		trap |=> trap)
		else $error("trap dropped without reset");

	idle_after_reset: assert property (@(posedge clk)
		$rose(resetn) |-> !mem_valid && !trap)
		else $error("core not idle when reset was released");

endmodule

//--- dv/rv_core_tb.sv
`timescale 1ns/1ps
`include "rv_defs.svh"

module rv_core_tb;

	localparam logic [31:0] DONE_ADDR = 32'h0000_03fc;
	localparam logic [2:0] ALU_F3 [0:5] = '{`RV_F3_ADD, `RV_F3_SLT, `RV_F3_SLTU,
		`RV_F3_XOR, `RV_F3_OR, `RV_F3_AND};
	localparam logic [2:0] BR_F3 [0:5] = '{`RV_F3_BEQ, `RV_F3_BNE, `RV_F3_BLT,
		`RV_F3_BGE, `RV_F3_BLTU, `RV_F3_BGEU};

	logic clk;
	logic resetn;
	logic trap;
	logic mem_valid;
	logic mem_instr;
	logic [31:0] mem_addr;
	logic [31:0] mem_wdata;
	logic [3:0] mem_wstrb;
	logic mem_ready;
	logic [31:0] mem_rdata;

	logic [31:0] mem [0:255];
	logic [7:0] wp;
	logic pending;
	logic use_delay;
	logic done_seen;
	logic fail_shown;
	logic pass_shown;
	int wait_cnt;
	int store_count;
	int data_reads;
	int emitted;
	int cycles;
	integer seed;

	rv_core uut (
		.clk(clk),
		.resetn(resetn),
		.trap(trap),
		.mem_valid(mem_valid),
		.mem_instr(mem_instr),
		.mem_addr(mem_addr),
		.mem_wdata(mem_wdata),
		.mem_wstrb(mem_wstrb),
		.mem_ready(mem_ready),
		.mem_rdata(mem_rdata)
	);

	bind rv_core rv_core_chk u_chk (
		.clk(clk),
		.resetn(resetn),
		.trap(trap),
		.mem_valid(mem_valid),
		.mem_instr(mem_instr),
		.mem_addr(mem_addr),
		.mem_wdata(mem_wdata),
		.mem_wstrb(mem_wstrb),
		.mem_ready(mem_ready)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// Memory model, answers 0 to 3 cycles after mem_valid
	always @(negedge clk) begin
		if (!resetn) begin
			mem_ready = 1'b0;
			pending = 1'b0;
		end else if (mem_ready) begin
			mem_ready = 1'b0;
			pending = 1'b0;
		end else if (mem_valid) begin
			if (!pending) begin
				pending = 1'b1;
				wait_cnt = use_delay ? {$random(seed)} % 4 : 0;
			end
			if (wait_cnt == 0) begin
				if (mem_wstrb != 4'b0000) begin
					assert (!mem_instr) else begin
						$display("a store to %h was marked as an instruction fetch",
							mem_addr);
						report_failure();
					end
					mem[mem_addr[9:2]] = mem_wdata;
					store_count++;
					if (mem_addr == DONE_ADDR)
						done_seen = 1'b1;
				end else begin
					if (!mem_instr)
						data_reads++;
					mem_rdata = mem[mem_addr[9:2]];
				end
				mem_ready = 1'b1;
			end else begin
				wait_cnt--;
			end
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > 200 * emitted + 2000) begin
			$display("timeout: the core did not finish its program in time");
			report_failure();
		end
	end

	final begin
		if (!pass_shown && !fail_shown)
			$display("SIMULATION FAILED");
	end

	task automatic report_failure();
		fail_shown = 1'b1;
		$display("SIMULATION FAILED");
		$fatal(1, "stopped at the first error");
	endtask

	function automatic logic [31:0] fill_word(input logic [7:0] idx);
		return 32'hbad0_0000 | {24'h0, idx};
	endfunction

	function automatic logic [31:0] enc_r(input logic [6:0] f7, input int rs2, input int rs1,
			input logic [2:0] f3, input int rd);
		return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], `RV_OPC_OP};
	endfunction

	function automatic logic [31:0] enc_i(input int imm, input int rs1, input logic [2:0] f3,
			input int rd, input logic [6:0] opc);
		return {imm[11:0], rs1[4:0], f3, rd[4:0], opc};
	endfunction

	function automatic logic [31:0] enc_s(input int imm, input int rs2, input int rs1);
		return {imm[11:5], rs2[4:0], rs1[4:0], `RV_F3_WORD, imm[4:0], `RV_OPC_STORE};
	endfunction

	function automatic logic [31:0] enc_b(input logic [2:0] f3, input int rs1, input int rs2,
			input int off);
		return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3, off[4:1], off[11], `RV_OPC_BRANCH};
	endfunction

	function automatic logic [31:0] enc_u(input int rd, input int hi20);
		return {hi20[19:0], rd[4:0], `RV_OPC_LUI};
	endfunction

	function automatic logic [31:0] enc_j(input int rd, input int off);
		return {off[20], off[10:1], off[11], off[19:12], rd[4:0], `RV_OPC_JAL};
	endfunction

	// RV32I reference results
	function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic sub,
			input logic [31:0] a, input logic [31:0] b);
		case (f3)
			`RV_F3_ADD: return sub ? a - b : a + b;
			`RV_F3_SLT: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			`RV_F3_SLTU: return (a < b) ? 32'd1 : 32'd0;
			`RV_F3_XOR: return a ^ b;
			`RV_F3_OR: return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic logic branch_ref(input logic [2:0] f3, input logic [31:0] a,
			input logic [31:0] b);
		case (f3)
			`RV_F3_BEQ: return a == b;
			`RV_F3_BNE: return a != b;
			`RV_F3_BLT: return $signed(a) < $signed(b);
			`RV_F3_BGE: return $signed(a) >= $signed(b);
			`RV_F3_BLTU: return a < b;
			default: return a >= b;
		endcase
	endfunction

	task automatic emit(input logic [31:0] ins);
		mem[wp] = ins;
		wp = wp + 8'd1;
		emitted++;
	endtask

	task automatic begin_prog();
		resetn = 1'b0;
		for (int i = 0; i < 256; i++)
			mem[i[7:0]] = fill_word(i[7:0]);
		wp = 8'd0;
	endtask

	task automatic emit_done();
		emit(enc_i(1, 0, `RV_F3_ADD, 31, `RV_OPC_OPIMM));
		emit(enc_s(32'h3fc, 31, 0));
	endtask

	task automatic run_prog();
		done_seen = 1'b0;
		store_count = 0;
		data_reads = 0;
		repeat (16) @(negedge clk);
		resetn = 1'b1;
		while (!done_seen && !trap)
			@(posedge clk);
		@(negedge clk);
	endtask

	task automatic check_word(input string name, input logic [31:0] addr,
			input logic [31:0] exp);
		logic [31:0] act;
		act = mem[addr[9:2]];
		assert (act === exp) else begin
			$display("mismatch %s: expected %h, actual %h", name, exp, act);
			report_failure();
		end
	endtask

	// Reads with mem_instr low, fetches must not count here
	task automatic check_data_reads(input string name, input int exp);
		assert (data_reads == exp) else begin
			$display("mismatch %s: expected %0d data reads, actual %0d", name, exp,
				data_reads);
			report_failure();
		end
	endtask

	task automatic check_trap(input string name);
		repeat (20) @(negedge clk);
		assert (trap === 1'b1 && !done_seen && store_count == 0) else begin
			$display("%s: the core did not stop with trap, or it stored after it", name);
			report_failure();
		end
	endtask

	task automatic test_alu(input string name);
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] exp_q [$];
		a = 32'h7fff_f234;
		b = 32'hffff_fffb;
		begin_prog();
		emit(enc_u(1, 32'h7ffff));
		emit(enc_i(32'h234, 1, `RV_F3_ADD, 1, `RV_OPC_OPIMM));
		emit(enc_i(-5, 0, `RV_F3_ADD, 2, `RV_OPC_OPIMM));
		for (int i = 0; i < 6; i++) begin
			emit(enc_r(`RV_F7_BASE, 2, 1, ALU_F3[i], 3));
			emit(enc_s(32'h100 + 4 * exp_q.size(), 3, 0));
			exp_q.push_back(alu_ref(ALU_F3[i], 1'b0, a, b));
		end
		emit(enc_r(`RV_F7_SUB, 2, 1, `RV_F3_ADD, 3));
		emit(enc_s(32'h100 + 4 * exp_q.size(), 3, 0));
		exp_q.push_back(alu_ref(`RV_F3_ADD, 1'b1, a, b));
		for (int i = 0; i < 6; i++) begin
			emit(enc_i(-5, 1, ALU_F3[i], 3, `RV_OPC_OPIMM));
			emit(enc_s(32'h100 + 4 * exp_q.size(), 3, 0));
			exp_q.push_back(alu_ref(ALU_F3[i], 1'b0, a, b));
		end
		// x0 must stay zero after a write
		emit(enc_i(1, 1, `RV_F3_ADD, 0, `RV_OPC_OPIMM));
		emit(enc_s(32'h100 + 4 * exp_q.size(), 0, 0));
		exp_q.push_back(32'h0);
		emit_done();
		run_prog();
		foreach (exp_q[k])
			check_word(name, 32'h100 + 32'(4 * k), exp_q[k]);
		check_data_reads(name, 0);
	endtask

	task automatic test_lui_lw();
		begin_prog();
		emit(enc_u(5, 32'hdeadb));
		emit(enc_i(-32'h111, 5, `RV_F3_ADD, 5, `RV_OPC_OPIMM));
		emit(enc_s(32'h180, 5, 0));
		emit(enc_i(32'h180, 0, `RV_F3_WORD, 6, `RV_OPC_LOAD));
		emit(enc_s(32'h184, 6, 0));
		emit_done();
		run_prog();
		check_word("lui_addi", 32'h180, 32'hdeada_eef);
		check_word("lw", 32'h184, 32'hdeada_eef);
		check_data_reads("lw", 1);
	endtask

	task automatic test_branch();
		logic [31:0] va [0:2];
		logic [31:0] vb [0:2];
		int ra [0:2];
		int rb [0:2];
		logic [31:0] link;
		int slot;
		va = '{32'hffff_fffb, 32'h3, 32'hffff_fffb};
		vb = '{32'h3, 32'hffff_fffb, 32'hffff_fffb};
		ra = '{1, 2, 1};
		rb = '{2, 1, 1};
		begin_prog();
		emit(enc_i(-5, 0, `RV_F3_ADD, 1, `RV_OPC_OPIMM));
		emit(enc_i(3, 0, `RV_F3_ADD, 2, `RV_OPC_OPIMM));
		for (int f = 0; f < 6; f++) begin
			for (int p = 0; p < 3; p++) begin
				slot = 32'h200 + 4 * (3 * f + p);
				emit(enc_b(BR_F3[f], ra[p], rb[p], 12));
				emit(enc_i(1, 0, `RV_F3_ADD, 7, `RV_OPC_OPIMM));
				emit(enc_j(0, 8));
				emit(enc_i(2, 0, `RV_F3_ADD, 7, `RV_OPC_OPIMM));
				emit(enc_s(slot, 7, 0));
			end
		end
		link = {22'h0, wp, 2'b00} + 32'd4;
		emit(enc_j(8, 8));
		emit(enc_s(32'h1f0, 1, 0));
		emit(enc_s(32'h1f4, 8, 0));
		emit_done();
		run_prog();
		for (int f = 0; f < 6; f++) begin
			for (int p = 0; p < 3; p++)
				check_word("branch", 32'h200 + 32'(4 * (3 * f + p)),
					branch_ref(BR_F3[f], va[p], vb[p]) ? 32'd2 : 32'd1);
		end
		check_word("jal_link", 32'h1f4, link);
		check_word("jal_skip", 32'h1f0, fill_word(8'h7c));
	endtask

	task automatic test_illegal();
		begin_prog();
		emit(enc_i(1, 0, `RV_F3_ADD, 1, `RV_OPC_OPIMM));
		// slli is outside the kept subset
		emit(enc_i(1, 1, 3'b001, 1, `RV_OPC_OPIMM));
		emit(enc_s(32'h300, 1, 0));
		emit_done();
		run_prog();
		check_trap("illegal");
	endtask

	task automatic test_misaligned();
		begin_prog();
		emit(enc_i(32'h102, 0, `RV_F3_ADD, 1, `RV_OPC_OPIMM));
		emit(enc_i(0, 1, `RV_F3_WORD, 2, `RV_OPC_LOAD));
		emit(enc_s(32'h300, 2, 0));
		emit_done();
		run_prog();
		check_trap("misaligned_lw");
	endtask

	initial begin
		seed = 32'h75d0;
		resetn = 1'b0;
		mem_ready = 1'b0;
		mem_rdata = 32'h0;
		use_delay = 1'b0;
		pending = 1'b0;
		done_seen = 1'b0;
		fail_shown = 1'b0;
		pass_shown = 1'b0;
		wait_cnt = 0;
		store_count = 0;
		data_reads = 0;
		emitted = 0;
		cycles = 0;
		@(negedge clk);
		test_alu("alu");
		test_lui_lw();
		test_branch();
		test_illegal();
		test_misaligned();
		use_delay = 1'b1;
		test_alu("alu_delayed");
		pass_shown = 1'b1;
		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

//--- hdl/rv_alu.sv
`timescale 1ns/1ps

module rv_alu (
	input  rv_pkg::alu_op_t op,
	input  rv_pkg::word_t   a,
	input  rv_pkg::word_t   b,
	output rv_pkg::word_t   result,
	output logic            cond
);
	import rv_pkg::*;

	logic is_eq;
	logic is_lt;
	logic is_ltu;

	assign is_eq = a == b;
	assign is_lt = $signed(a) < $signed(b);
	assign is_ltu = a < b;

	always_comb begin
		case (op)
			alu_eq: cond = is_eq;
			alu_ne: cond = !is_eq;
			alu_slt, alu_lt: cond = is_lt;
			alu_ge: cond = !is_lt;
			alu_sltu, alu_ltu: cond = is_ltu;
			alu_geu: cond = !is_ltu;
			default: cond = 1'b0;
		endcase
	end

	always_comb begin
		case (op)
			alu_add: result = a + b;
			alu_sub: result = a - b;
			alu_xor: result = a ^ b;
			alu_or: result = a | b;
			alu_and: result = a & b;
			alu_pass_b: result = b;
			// Compares give 0 or 1
			default: result = word_t'(cond);
		endcase
	end

endmodule

//--- hdl/rv_control.sv
`timescale 1ns/1ps
`include "rv_defs.svh"

module rv_control (
	input  logic                clk,
	input  logic                resetn,
	input  logic                mem_done,
	input  rv_pkg::word_t       mem_rdata,
	output logic                do_rinst,
	output logic                do_rdata,
	output logic                do_wdata,
	output rv_pkg::word_t       mem_addr_req,
	output rv_pkg::word_t       mem_wdata_req,
	output logic                instr_load,
	input  rv_pkg::instr_kind_t kind,
	input  rv_pkg::alu_op_t     dec_alu_op,
	input  rv_pkg::reg_idx_t    rd,
	input  rv_pkg::reg_idx_t    rs1,
	input  rv_pkg::reg_idx_t    rs2,
	input  rv_pkg::word_t       imm,
	output rv_pkg::reg_idx_t    raddr1,
	output rv_pkg::reg_idx_t    raddr2,
	input  rv_pkg::word_t       rdata1,
	input  rv_pkg::word_t       rdata2,
	output logic                we,
	output rv_pkg::reg_idx_t    waddr,
	output rv_pkg::word_t       wdata,
	output rv_pkg::alu_op_t     alu_op,
	output rv_pkg::word_t       op1,
	output rv_pkg::word_t       op2,
	input  rv_pkg::word_t       alu_result,
	input  logic                alu_cond,
	output logic                trap
);
	import rv_pkg::*;

	cpu_state_t state;
	word_t pc;
	word_t pc_next4;
	word_t target;
	word_t ls_addr;
	logic busy;
	logic ls_aligned;
	logic take;

	assign pc_next4 = pc + 32'd4;
	assign target = pc + imm;
	assign ls_addr = op1 + imm;
	assign ls_aligned = ls_addr[1:0] == 2'b00;
	assign take = kind == kind_jal || (kind == kind_branch && alu_cond);

	assign raddr1 = rs1;
	assign raddr2 = rs2;
	assign waddr = rd;
	assign alu_op = dec_alu_op;
	assign trap = state == cpu_trap;

	assign mem_addr_req = (state == cpu_fetch) ? pc : ls_addr;
	assign mem_wdata_req = op2;

	// One request per memory state, issued while not yet busy
	assign do_rinst = state == cpu_fetch && !busy;
	assign do_rdata = state == cpu_ldmem && !busy && ls_aligned;
	assign do_wdata = state == cpu_stmem && !busy && ls_aligned;
	assign instr_load = state == cpu_fetch && mem_done;

	always_comb begin
		we = 1'b0;
		wdata = alu_result;
		case (state)
			cpu_exec: begin
				we = kind != kind_branch;
				if (kind == kind_jal)
					wdata = pc_next4;
			end
			cpu_ldmem: begin
				we = mem_done;
				wdata = mem_rdata;
			end
			default: we = 1'b0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (state == cpu_ld_rs1) begin
			op1 <= rdata1;
			op2 <= imm;
		end else if (state == cpu_ld_rs2) begin
			op2 <= rdata2;
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			state <= cpu_fetch;
			pc <= `RV_RESET_PC;
			busy <= 1'b0;
		end else begin
			case (state)
				cpu_fetch: begin
					if (!busy) begin
						busy <= 1'b1;
					end else if (mem_done) begin
						busy <= 1'b0;
						state <= cpu_ld_rs1;
					end
				end
				cpu_ld_rs1: begin
					case (kind)
						kind_lui, kind_alu_imm, kind_jal: state <= cpu_exec;
						kind_load: state <= cpu_ldmem;
						kind_alu_reg, kind_branch, kind_store: state <= cpu_ld_rs2;
						default: state <= cpu_trap;
					endcase
				end
				cpu_ld_rs2: begin
					state <= (kind == kind_store) ? cpu_stmem : cpu_exec;
				end
				cpu_exec: begin
					if (!take) begin
						pc <= pc_next4;
						state <= cpu_fetch;
					end else if (target[1:0] != 2'b00) begin
						state <= cpu_trap;
					end else begin
						pc <= target;
						state <= cpu_fetch;
					end
				end
				cpu_ldmem, cpu_stmem: begin
					if (!ls_aligned) begin
						state <= cpu_trap;
					end else if (!busy) begin
						busy <= 1'b1;
					end else if (mem_done) begin
						busy <= 1'b0;
						pc <= pc_next4;
						state <= cpu_fetch;
					end
				end
				// Trap holds until reset
				default: state <= cpu_trap;
			endcase
		end
	end

endmodule

//--- hdl/rv_core.sv
`timescale 1ns/1ps

module rv_core (
	input  logic          clk,
	input  logic          resetn,
	output logic          trap,
	output logic          mem_valid,
	output logic          mem_instr,
	output rv_pkg::word_t mem_addr,
	output rv_pkg::word_t mem_wdata,
	output logic [3:0]    mem_wstrb,
	input  logic          mem_ready,
	input  rv_pkg::word_t mem_rdata
);
	import rv_pkg::*;

	logic do_rinst, do_rdata, do_wdata;
	logic mem_done;
	logic instr_load;
	logic we;
	logic alu_cond;
	word_t mem_addr_req, mem_wdata_req;
	word_t imm, rdata1, rdata2, wdata;
	word_t op1, op2, alu_result;
	instr_kind_t kind;
	alu_op_t dec_alu_op, alu_op;
	reg_idx_t rd, rs1, rs2, raddr1, raddr2, waddr;

	rv_control u_control (
		.clk(clk),
		.resetn(resetn),
		.mem_done(mem_done),
		.mem_rdata(mem_rdata),
		.do_rinst(do_rinst),
		.do_rdata(do_rdata),
		.do_wdata(do_wdata),
		.mem_addr_req(mem_addr_req),
		.mem_wdata_req(mem_wdata_req),
		.instr_load(instr_load),
		.kind(kind),
		.dec_alu_op(dec_alu_op),
		.rd(rd),
		.rs1(rs1),
		.rs2(rs2),
		.imm(imm),
		.raddr1(raddr1),
		.raddr2(raddr2),
		.rdata1(rdata1),
		.rdata2(rdata2),
		.we(we),
		.waddr(waddr),
		.wdata(wdata),
		.alu_op(alu_op),
		.op1(op1),
		.op2(op2),
		.alu_result(alu_result),
		.alu_cond(alu_cond),
		.trap(trap)
	);

	rv_decoder u_decoder (
		.clk(clk),
		.instr_load(instr_load),
		.instr(mem_rdata),
		.kind(kind),
		.alu_op(dec_alu_op),
		.rd(rd),
		.rs1(rs1),
		.rs2(rs2),
		.imm(imm)
	);

	rv_regfile u_regfile (
		.clk(clk),
		.raddr1(raddr1),
		.raddr2(raddr2),
		.rdata1(rdata1),
		.rdata2(rdata2),
		.we(we),
		.waddr(waddr),
		.wdata(wdata)
	);

	rv_alu u_alu (
		.op(alu_op),
		.a(op1),
		.b(op2),
		.result(alu_result),
		.cond(alu_cond)
	);

	rv_mem_if u_mem_if (
		.clk(clk),
		.resetn(resetn),
		.do_rinst(do_rinst),
		.do_rdata(do_rdata),
		.do_wdata(do_wdata),
		.addr(mem_addr_req),
		.wdata(mem_wdata_req),
		.mem_done(mem_done),
		.mem_valid(mem_valid),
		.mem_instr(mem_instr),
		.mem_addr(mem_addr),
		.mem_wdata(mem_wdata),
		.mem_wstrb(mem_wstrb),
		.mem_ready(mem_ready)
	);

endmodule

//--- hdl/rv_decoder.sv
`timescale 1ns/1ps
`include "rv_defs.svh"

module rv_decoder (
	input  logic                clk,
	input  logic                instr_load,
	input  rv_pkg::word_t       instr,
	output rv_pkg::instr_kind_t kind,
	output rv_pkg::alu_op_t     alu_op,
	output rv_pkg::reg_idx_t    rd,
	output rv_pkg::reg_idx_t    rs1,
	output rv_pkg::reg_idx_t    rs2,
	output rv_pkg::word_t       imm
);
	import rv_pkg::*;

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	instr_kind_t next_kind;
	alu_op_t next_op;
	word_t next_imm;
	word_t imm_i;
	word_t imm_s;
	word_t imm_b;
	word_t imm_u;
	word_t imm_j;

	assign opcode = instr[6:0];
	assign funct3 = instr[14:12];
	assign funct7 = instr[31:25];

	assign imm_i = {{20{instr[31]}}, instr[31:20]};
	assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
	assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
	assign imm_u = {instr[31:12], 12'b0};
	assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

	always_comb begin
		next_kind = kind_illegal;
		next_op = alu_add;
		next_imm = '0;
		case (opcode)
			`RV_OPC_LUI: begin
				next_kind = kind_lui;
				next_op = alu_pass_b;
				next_imm = imm_u;
			end
			`RV_OPC_JAL: begin
				next_kind = kind_jal;
				next_imm = imm_j;
			end
			`RV_OPC_BRANCH: begin
				next_kind = kind_branch;
				next_imm = imm_b;
				case (funct3)
					`RV_F3_BEQ: next_op = alu_eq;
					`RV_F3_BNE: next_op = alu_ne;
					`RV_F3_BLT: next_op = alu_lt;
					`RV_F3_BGE: next_op = alu_ge;
					`RV_F3_BLTU: next_op = alu_ltu;
					`RV_F3_BGEU: next_op = alu_geu;
					default: next_kind = kind_illegal;
				endcase
			end
			`RV_OPC_LOAD: begin
				next_imm = imm_i;
				if (funct3 == `RV_F3_WORD)
					next_kind = kind_load;
			end
			`RV_OPC_STORE: begin
				next_imm = imm_s;
				if (funct3 == `RV_F3_WORD)
					next_kind = kind_store;
			end
			`RV_OPC_OPIMM, `RV_OPC_OP: begin
				next_kind = (opcode == `RV_OPC_OP) ? kind_alu_reg : kind_alu_imm;
				next_imm = imm_i;
				case (funct3)
					`RV_F3_ADD: next_op = alu_add;
					`RV_F3_SLT: next_op = alu_slt;
					`RV_F3_SLTU: next_op = alu_sltu;
					`RV_F3_XOR: next_op = alu_xor;
					`RV_F3_OR: next_op = alu_or;
					`RV_F3_AND: next_op = alu_and;
					// Shifts are not implemented
					default: next_kind = kind_illegal;
				endcase
				if (opcode == `RV_OPC_OP && funct7 != `RV_F7_BASE) begin
					if (funct7 == `RV_F7_SUB && funct3 == `RV_F3_ADD)
						next_op = alu_sub;
					else
						next_kind = kind_illegal;
				end
			end
			default: next_kind = kind_illegal;
		endcase
	end

	always_ff @(posedge clk) begin
		if (instr_load) begin
			kind <= next_kind;
			alu_op <= next_op;
			imm <= next_imm;
			rd <= instr[11:7];
			rs1 <= instr[19:15];
			rs2 <= instr[24:20];
		end
	end

endmodule

//--- hdl/rv_defs.svh
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

`define RV_XLEN          32
`define RV_REG_COUNT     32
`define RV_REGIDX_BITS   5
`define RV_RESET_PC      32'h0000_0000

// Major opcodes
`define RV_OPC_LUI       7'b0110111
`define RV_OPC_JAL       7'b1101111
`define RV_OPC_BRANCH    7'b1100011
`define RV_OPC_LOAD      7'b0000011
`define RV_OPC_STORE     7'b0100011
`define RV_OPC_OPIMM     7'b0010011
`define RV_OPC_OP        7'b0110011

// funct3 for OP and OP-IMM
`define RV_F3_ADD        3'b000
`define RV_F3_SLT        3'b010
`define RV_F3_SLTU       3'b011
`define RV_F3_XOR        3'b100
`define RV_F3_OR         3'b110
`define RV_F3_AND        3'b111

// funct3 for branches
`define RV_F3_BEQ        3'b000
`define RV_F3_BNE        3'b001
`define RV_F3_BLT        3'b100
`define RV_F3_BGE        3'b101
`define RV_F3_BLTU       3'b110
`define RV_F3_BGEU       3'b111

`define RV_F3_WORD       3'b010
`define RV_F7_BASE       7'b0000000
`define RV_F7_SUB        7'b0100000

`endif

//--- hdl/rv_mem_if.sv
`timescale 1ns/1ps

module rv_mem_if (
	input  logic          clk,
	input  logic          resetn,
	input  logic          do_rinst,
	input  logic          do_rdata,
	input  logic          do_wdata,
	input  rv_pkg::word_t addr,
	input  rv_pkg::word_t wdata,
	output logic          mem_done,
	output logic          mem_valid,
	output logic          mem_instr,
	output rv_pkg::word_t mem_addr,
	output rv_pkg::word_t mem_wdata,
	output logic [3:0]    mem_wstrb,
	input  logic          mem_ready
);
	import rv_pkg::*;

	mem_state_t state;
	logic start;

	assign start = state == mem_idle && (do_rinst || do_rdata || do_wdata);
	assign mem_valid = state != mem_idle;
	assign mem_done = mem_valid && mem_ready;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			state <= mem_idle;
			mem_instr <= 1'b0;
			mem_wstrb <= 4'b0000;
		end else begin
			case (state)
				mem_idle: begin
					if (do_rinst || do_rdata) begin
						state <= mem_read;
						mem_instr <= do_rinst;
						mem_wstrb <= 4'b0000;
					end else if (do_wdata) begin
						state <= mem_write;
						mem_instr <= 1'b0;
						mem_wstrb <= 4'b1111;
					end
				end
				mem_read, mem_write: begin
					// Wait as long as the memory needs
					if (mem_ready)
						state <= mem_idle;
				end
				default: state <= mem_idle;
			endcase
		end
	end

	// Held stable for the whole transfer
	always_ff @(posedge clk) begin
		if (start) begin
			mem_addr <= addr;
			mem_wdata <= wdata;
		end
	end

endmodule

//--- hdl/rv_pkg.sv
`include "rv_defs.svh"

package rv_pkg;

	typedef logic [`RV_XLEN-1:0] word_t;
	typedef logic [`RV_REGIDX_BITS-1:0] reg_idx_t;

	// Compare ops at the end share the cond output
	typedef enum logic [3:0] {
		alu_add,
		alu_sub,
		alu_slt,
		alu_sltu,
		alu_xor,
		alu_or,
		alu_and,
		alu_eq,
		alu_ne,
		alu_lt,
		alu_ge,
		alu_ltu,
		alu_geu,
		alu_pass_b
	} alu_op_t;

	typedef enum logic [2:0] {
		kind_alu_reg,
		kind_alu_imm,
		kind_lui,
		kind_jal,
		kind_branch,
		kind_load,
		kind_store,
		kind_illegal
	} instr_kind_t;

	typedef enum logic [2:0] {
		cpu_fetch,
		cpu_ld_rs1,
		cpu_ld_rs2,
		cpu_exec,
		cpu_ldmem,
		cpu_stmem,
		cpu_trap
	} cpu_state_t;

	typedef enum logic [1:0] {
		mem_idle,
		mem_read,
		mem_write
	} mem_state_t;

endpackage

//--- hdl/rv_regfile.sv
`timescale 1ns/1ps
`include "rv_defs.svh"

module rv_regfile (
	input  logic             clk,
	input  rv_pkg::reg_idx_t raddr1,
	input  rv_pkg::reg_idx_t raddr2,
	output rv_pkg::word_t    rdata1,
	output rv_pkg::word_t    rdata2,
	input  logic             we,
	input  rv_pkg::reg_idx_t waddr,
	input  rv_pkg::word_t    wdata
);
	import rv_pkg::*;

	word_t regs [0:`RV_REG_COUNT-1];

	// x0 is never written
	always_ff @(posedge clk) begin
		if (we && waddr != '0) begin
			regs[waddr] <= wdata;
		end
	end

	assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
	assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f tb.f --top-module rv_core_tb \
	&& ./obj_dir/Vrv_core_tb | tee /dev/stderr | grep -q "SIMULATION PASSED" \
	&& exit 0 \
	|| exit 1

//--- tb.f
+incdir+hdl
hdl/rv_pkg.sv
hdl/rv_decoder.sv
hdl/rv_regfile.sv
hdl/rv_alu.sv
hdl/rv_mem_if.sv
hdl/rv_control.sv
hdl/rv_core.sv
dv/rv_core_chk.sv
dv/rv_core_tb.sv
